// ==== common/eth_rx_pkg.sv ====
// Ethernet receive path types
`default_nettype none

package eth_rx_pkg;

    // MAC side beat
    localparam int narrow_data_width = 64;
    localparam int narrow_keep_width = narrow_data_width / 8;

    // Buffer and output word
    localparam int wide_data_width = 256;
    localparam int wide_keep_width = wide_data_width / 8;

    // Narrow beats per wide word
    localparam int lane_ratio = wide_data_width / narrow_data_width;

    typedef struct packed {
        logic [narrow_data_width-1:0] data;
        logic [narrow_keep_width-1:0] keep;
        logic                         last;
        logic                         bad;
    } narrow_beat_t;

    typedef struct packed {
        logic [wide_data_width-1:0] data;
        logic [wide_keep_width-1:0] keep;
        logic                       last;
        logic                       bad;
    } wide_beat_t;

    // Stored word without the bad flag
    typedef struct packed {
        logic [wide_data_width-1:0] data;
        logic [wide_keep_width-1:0] keep;
        logic                       last;
    } wide_word_t;

    // Single-cycle FIFO status pulses
    typedef struct packed {
        logic overflow;
        logic bad_frame;
        logic good_frame;
    } rx_status_t;

endpackage

`default_nettype wire

// ==== run_sim.sh ====
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f src.f --top-module tb_eth_rx_path -o sim_tb
./obj_dir/sim_tb > sim.log 2>&1
cat sim.log

if grep -q "Regression failed" sim.log; then
    exit 1
fi

// ==== rx_fifo/rx_frame_fifo.sv ====
// Receive frame FIFO
`timescale 1ns/1ps
`default_nettype none

module rx_frame_fifo #(
    parameter int fifo_addr_width = 4
) (
    input  wire logic                    logic_clk,
    input  wire logic                    logic_rst,
    input  wire eth_rx_pkg::wide_beat_t  up_beat,
    input  wire logic                    up_valid,
    output eth_rx_pkg::wide_word_t       buf_word,
    output logic                         buf_avail,
    input  wire logic                    buf_pop,
    output eth_rx_pkg::rx_status_t       status
);

    import eth_rx_pkg::*;

    localparam int depth = 2 ** fifo_addr_width;

    wide_word_t mem [depth];

    // Pointers carry one extra wrap bit
    logic [fifo_addr_width:0] wr_ptr;
    logic [fifo_addr_width:0] wr_commit;
    logic [fifo_addr_width:0] rd_ptr;

    logic       drop_frame;
    logic       frame_bad;
    logic       full;
    logic       wr_en;
    logic       frame_is_bad;
    wide_word_t wr_word;

    // Full counts speculative words too
    assign full = (wr_ptr[fifo_addr_width] != rd_ptr[fifo_addr_width]) &&
                  (wr_ptr[fifo_addr_width-1:0] == rd_ptr[fifo_addr_width-1:0]);

    assign wr_en        = up_valid && !drop_frame && !full;
    assign frame_is_bad = frame_bad | up_beat.bad;

    assign wr_word = '{data: up_beat.data, keep: up_beat.keep, last: up_beat.last};

    // Only committed words are visible to the reader
    assign buf_avail = (wr_commit != rd_ptr);
    assign buf_word  = mem[rd_ptr[fifo_addr_width-1:0]];

    always_ff @(posedge logic_clk) begin
        if (wr_en) begin
            mem[wr_ptr[fifo_addr_width-1:0]] <= wr_word;
        end
    end

    always_ff @(posedge logic_clk or posedge logic_rst) begin
        if (logic_rst) begin
            wr_ptr     <= '0;
            wr_commit  <= '0;
            drop_frame <= 1'b0;
            frame_bad  <= 1'b0;
            status     <= '0;
        end else begin
            status <= '0;

            if (up_valid) begin
                if (drop_frame) begin
                    // Discard the rest of an overflowed frame
                    if (up_beat.last) begin
                        drop_frame <= 1'b0;
                    end
                end else if (full) begin
                    wr_ptr          <= wr_commit;
                    frame_bad       <= 1'b0;
                    status.overflow <= 1'b1;
                    drop_frame      <= !up_beat.last;
                end else if (up_beat.last) begin
                    frame_bad <= 1'b0;
                    if (frame_is_bad) begin
                        wr_ptr           <= wr_commit;
                        status.bad_frame <= 1'b1;
                    end else begin
                        wr_ptr            <= wr_ptr + 1'b1;
                        wr_commit         <= wr_ptr + 1'b1;
                        status.good_frame <= 1'b1;
                    end
                end else begin
                    wr_ptr    <= wr_ptr + 1'b1;
                    frame_bad <= frame_is_bad;
                end
            end
        end
    end

    // Read side
    always_ff @(posedge logic_clk or posedge logic_rst) begin
        if (logic_rst) begin
            rd_ptr <= '0;
        end else if (buf_pop) begin
            rd_ptr <= rd_ptr + 1'b1;
        end
    end

    // Sender must wait for a committed word
    property p_pop_needs_data;
        @(posedge logic_clk) disable iff (logic_rst)
            buf_pop |-> buf_avail;
    endproperty

    a_pop_needs_data: assert property (p_pop_needs_data)
        else $error("buf_pop while no committed word is stored");

endmodule

`default_nettype wire

// ==== src.f ====
common/eth_rx_pkg.sv
src/rx_width_upsizer.sv
rx_fifo/rx_frame_fifo.sv
src/rx_credit_sender.sv
src/eth_rx_path.sv
tb/tb_clock_gen.sv
tb/rx_checker.sv
tb/tb_eth_rx_path.sv

// ==== src/eth_rx_path.sv ====
// Ethernet receive path top
`timescale 1ns/1ps
`default_nettype none

module eth_rx_path #(
    parameter int fifo_addr_width = 4,
    parameter int credit_max      = 8
) (
    input  wire logic                      logic_clk,
    input  wire logic                      logic_rst,
    input  wire eth_rx_pkg::narrow_beat_t  in_beat,
    input  wire logic                      in_valid,
    input  wire logic                      credit_return,
    output eth_rx_pkg::wide_word_t         out_word,
    output logic                           out_valid,
    output eth_rx_pkg::rx_status_t         status
);

    import eth_rx_pkg::*;

    wide_beat_t up_beat;
    logic       up_valid;
    wide_word_t buf_word;
    logic       buf_avail;
    logic       buf_pop;

    rx_width_upsizer u_upsizer (
        .logic_clk (logic_clk),
        .logic_rst (logic_rst),
        .in_beat   (in_beat),
        .in_valid  (in_valid),
        .up_beat   (up_beat),
        .up_valid  (up_valid)
    );

    rx_frame_fifo #(
        .fifo_addr_width (fifo_addr_width)
    ) u_fifo (
        .logic_clk (logic_clk),
        .logic_rst (logic_rst),
        .up_beat   (up_beat),
        .up_valid  (up_valid),
        .buf_word  (buf_word),
        .buf_avail (buf_avail),
        .buf_pop   (buf_pop),
        .status    (status)
    );

    rx_credit_sender #(
        .credit_max (credit_max)
    ) u_sender (
        .logic_clk     (logic_clk),
        .logic_rst     (logic_rst),
        .buf_word      (buf_word),
        .buf_avail     (buf_avail),
        .buf_pop       (buf_pop),
        .credit_return (credit_return),
        .out_word      (out_word),
        .out_valid     (out_valid)
    );

endmodule

`default_nettype wire

// ==== src/rx_credit_sender.sv ====
// Credit based output stage
`timescale 1ns/1ps
`default_nettype none

module rx_credit_sender #(
    parameter int credit_max = 8
) (
    input  wire logic                    logic_clk,
    input  wire logic                    logic_rst,
    input  wire eth_rx_pkg::wide_word_t  buf_word,
    input  wire logic                    buf_avail,
    output logic                         buf_pop,
    input  wire logic                    credit_return,
    output eth_rx_pkg::wide_word_t       out_word,
    output logic                         out_valid
);

    import eth_rx_pkg::*;

    // One spare bit so an excess grant is visible
    localparam int credit_width = $clog2(credit_max + 1) + 1;

    logic [credit_width-1:0] credit_cnt;

    assign buf_pop = buf_avail && (credit_cnt != '0);

    always_ff @(posedge logic_clk or posedge logic_rst) begin
        if (logic_rst) begin
            credit_cnt <= '0;
            out_valid  <= 1'b0;
        end else begin
            out_valid <= buf_pop;
            case ({credit_return, buf_pop})
                2'b10:   credit_cnt <= credit_cnt + 1'b1;
                2'b01:   credit_cnt <= credit_cnt - 1'b1;
                default: credit_cnt <= credit_cnt;
            endcase
        end
    end

    always_ff @(posedge logic_clk) begin
        if (buf_pop) begin
            out_word <= buf_word;
        end
    end

    // Consumer grants at most credit_max outstanding credits
    a_credit_bound: assert property (
        @(posedge logic_clk) disable iff (logic_rst) credit_cnt <= credit_max)
        else $error("credit count above credit_max");

endmodule

`default_nettype wire

// ==== src/rx_width_upsizer.sv ====
// Narrow to wide beat packer
`timescale 1ns/1ps
`default_nettype none

module rx_width_upsizer (
    input  wire logic                      logic_clk,
    input  wire logic                      logic_rst,
    input  wire eth_rx_pkg::narrow_beat_t  in_beat,
    input  wire logic                      in_valid,
    output eth_rx_pkg::wide_beat_t         up_beat,
    output logic                           up_valid
);

    import eth_rx_pkg::*;

    localparam int lane_width = $clog2(lane_ratio);
    localparam logic [lane_width-1:0] last_lane = lane_width'(lane_ratio - 1);

    logic [lane_width-1:0] lane_idx;
    wide_beat_t            acc;
    wide_beat_t            acc_base;
    wide_beat_t            acc_next;
    logic                  word_done;

    // Word closes on the final lane or on the end of the frame
    assign word_done = in_beat.last || (lane_idx == last_lane);

    // Lane 0 starts a fresh word, so unfilled lanes stay zero
    assign acc_base = (lane_idx == '0) ? '0 : acc;

    always_comb begin
        acc_next = acc_base;
        acc_next.data[lane_idx*narrow_data_width +: narrow_data_width] = in_beat.data;
        acc_next.keep[lane_idx*narrow_keep_width +: narrow_keep_width] = in_beat.keep;
        acc_next.bad  = acc_base.bad | in_beat.bad;
        acc_next.last = in_beat.last;
    end

    always_ff @(posedge logic_clk or posedge logic_rst) begin
        if (logic_rst) begin
            lane_idx <= '0;
            up_valid <= 1'b0;
        end else begin
            up_valid <= in_valid && word_done;
            if (in_valid) begin
                if (word_done) begin
                    lane_idx <= '0;
                end else begin
                    lane_idx <= lane_idx + 1'b1;
                end
            end
        end
    end

    // Accumulator and output word
    always_ff @(posedge logic_clk) begin
        if (in_valid) begin
            acc <= acc_next;
            if (word_done) begin
                up_beat <= acc_next;
            end
        end
    end

    // Partial keep only allowed at end of frame
    property p_keep_full_mid_frame;
        @(posedge logic_clk) disable iff (logic_rst)
            (in_valid && !in_beat.last) |-> (&in_beat.keep);
    endproperty

    a_keep_full_mid_frame: assert property (p_keep_full_mid_frame)
        else $error("partial keep on a beat without last");

endmodule

`default_nettype wire

// ==== tb/rx_checker.sv ====
// Receive path output checker
`timescale 1ns/1ps
`default_nettype none

module rx_checker (
    input wire logic                    logic_clk,
    input wire logic                    logic_rst,
    input wire eth_rx_pkg::wide_word_t  out_word,
    input wire logic                    out_valid,
    input wire logic                    credit_return,
    input wire eth_rx_pkg::rx_status_t  status
);

    import eth_rx_pkg::*;

    wide_word_t exp_q [$];
    int words_seen   = 0;
    int credits_seen = 0;
    int good_seen    = 0;
    int bad_seen     = 0;
    int ovf_seen     = 0;
    int error_count  = 0;
    int test_errors  = 0;
    int tests_run    = 0;

    task automatic expect_word(input wide_word_t w);
        exp_q.push_back(w);
    endtask

    task automatic note_error();
        error_count++;
        test_errors++;
    endtask

    task automatic check_count(input string name, input int expv, input int got);
        if (expv != got) begin
            $display("Error at %0t: %s expected %0d got %0d", $time, name, expv, got);
            note_error();
        end
    endtask

    task automatic compare_word(input wide_word_t expv, input wide_word_t got);
        if (got.data !== expv.data) begin
            $display("Error at %0t: out_word.data expected %h got %h",
                     $time, expv.data, got.data);
            note_error();
        end
        if (got.keep !== expv.keep) begin
            $display("Error at %0t: out_word.keep expected %h got %h",
                     $time, expv.keep, got.keep);
            note_error();
        end
        if (got.last !== expv.last) begin
            $display("Error at %0t: out_word.last expected %b got %b",
                     $time, expv.last, got.last);
            note_error();
        end
    endtask

    // Outputs are registered, so the values seen here belong to the past cycle
    always @(posedge logic_clk) begin : sample
        wide_word_t expv;
        if (!logic_rst) begin
            credits_seen += int'(credit_return);
            good_seen    += int'(status.good_frame);
            bad_seen     += int'(status.bad_frame);
            ovf_seen     += int'(status.overflow);
            if (out_valid) begin
                words_seen++;
                if (exp_q.size() == 0) begin
                    $display("A word arrived on out_word at %0t with no frame expected", $time);
                    note_error();
                end else begin
                    expv = exp_q.pop_front();
                    compare_word(expv, out_word);
                end
            end
            if (words_seen > credits_seen) begin
                $display("At %0t more words left the DUT than credits were returned", $time);
                note_error();
            end
        end
    end

    // Status counts are cumulative over the run
    task automatic report_test(input int idx, input int len, input int exp_good,
                               input int exp_bad, input int exp_ovf);
        check_count("status.good_frame pulses", exp_good, good_seen);
        check_count("status.bad_frame pulses", exp_bad, bad_seen);
        check_count("status.overflow pulses", exp_ovf, ovf_seen);
        if (test_errors == 0) begin
            $display("Test %0d (%0d bytes): ok", idx, len);
        end else begin
            $display("Test %0d (%0d bytes): %0d errors", idx, len, test_errors);
        end
        test_errors = 0;
        tests_run++;
    endtask

    task automatic final_check(input int exp_words);
        if (exp_q.size() != 0) begin
            $display("%0d expected words never appeared on out_word", exp_q.size());
            note_error();
        end
        check_count("out_valid cycles", exp_words, words_seen);
        $display("Summary: %0d tests, %0d words, %0d credits, %0d errors",
                 tests_run, words_seen, credits_seen, error_count);
    endtask

endmodule

`default_nettype wire

// ==== tb/tb_clock_gen.sv ====
// Testbench clock and reset
`timescale 1ns/1ps
`default_nettype none

module tb_clock_gen (
    output logic logic_clk,
    output logic logic_rst
);

    // 100 ns period
    initial begin
        logic_clk = 1'b0;
        forever #50 logic_clk = ~logic_clk;
    end

    // Held for four rising edges, released mid-cycle
    initial begin
        logic_rst = 1'b1;
        repeat (4) @(posedge logic_clk);
        @(negedge logic_clk);
        logic_rst = 1'b0;
    end

endmodule

`default_nettype wire

// ==== tb/tb_eth_rx_path.sv ====
// Receive path testbench
`timescale 1ns/1ps
`default_nettype none

module tb_eth_rx_path;

    import eth_rx_pkg::*;

    localparam int fifo_addr_width = 4;
    localparam int credit_max      = 8;
    localparam int fifo_depth      = 2 ** fifo_addr_width;
    localparam int num_rows        = 13;
    localparam int wait_limit      = 2000;

    typedef struct packed {
        int len;
        bit bad;
        bit withheld;
    } frame_row_t;

    // Length in bytes, bad flag, credits withheld during the frame
    frame_row_t rows [num_rows] = '{
        '{64, 1'b0, 1'b0},  '{128, 1'b0, 1'b0}, '{45, 1'b0, 1'b0},
        '{77, 1'b1, 1'b0},  '{100, 1'b0, 1'b0}, '{3, 1'b0, 1'b0},
        '{96, 1'b0, 1'b1},  '{600, 1'b0, 1'b1}, '{200, 1'b0, 1'b0},
        '{512, 1'b0, 1'b1}, '{33, 1'b0, 1'b0},  '{256, 1'b1, 1'b1},
        '{31, 1'b0, 1'b0}
    };

    logic         logic_clk;
    logic         logic_rst;
    narrow_beat_t in_beat       = '0;
    logic         in_valid      = 1'b0;
    logic         credit_return = 1'b0;
    wide_word_t   out_word;
    logic         out_valid;
    rx_status_t   status;

    logic [31:0] rng = 32'hc519;
    logic [7:0]  payload [1024];
    logic        credits_on = 1'b0;
    int          granted    = 0;
    int          pushed     = 0;
    int          exp_good   = 0;
    int          exp_bad    = 0;
    int          exp_ovf    = 0;
    event        hang_ev;
    string       hang_reason;

    tb_clock_gen clk_gen (.logic_clk(logic_clk), .logic_rst(logic_rst));

    eth_rx_path #(
        .fifo_addr_width (fifo_addr_width),
        .credit_max      (credit_max)
    ) dut (
        .logic_clk     (logic_clk),
        .logic_rst     (logic_rst),
        .in_beat       (in_beat),
        .in_valid      (in_valid),
        .credit_return (credit_return),
        .out_word      (out_word),
        .out_valid     (out_valid),
        .status        (status)
    );

    rx_checker chk (
        .logic_clk     (logic_clk),
        .logic_rst     (logic_rst),
        .out_word      (out_word),
        .out_valid     (out_valid),
        .credit_return (credit_return),
        .status        (status)
    );

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    task automatic give_up(input string why);
        hang_reason = why;
        -> hang_ev;
        #100;
    endtask

    initial begin
        @(hang_ev);
        $display("Timeout: %s", hang_reason);
        $display("Regression failed");
        $finish;
    end

    // Grant only what expected words can consume, never above credit_max
    always @(negedge logic_clk) begin
        if (credits_on && !logic_rst && granted < pushed &&
            (granted - chk.words_seen) < credit_max) begin
            credit_return = 1'b1;
            granted++;
        end else begin
            credit_return = 1'b0;
        end
    end

    task automatic wait_reset_release();
        int n;
        n = 0;
        @(negedge logic_clk);
        while (logic_rst && n < wait_limit) begin
            @(negedge logic_clk);
            n++;
        end
        if (logic_rst) begin
            give_up("reset was never released");
        end
    endtask

    task automatic wait_drain();
        int n;
        n = 0;
        while ((pushed - chk.words_seen) != 0 && n < wait_limit) begin
            @(negedge logic_clk);
            n++;
        end
        if ((pushed - chk.words_seen) != 0) begin
            give_up("the expected words never all left the DUT");
        end
    endtask

    task automatic wait_status(input int total);
        int n;
        n = 0;
        while ((chk.good_seen + chk.bad_seen + chk.ovf_seen) < total && n < wait_limit) begin
            @(negedge logic_clk);
            n++;
        end
        if ((chk.good_seen + chk.bad_seen + chk.ovf_seen) < total) begin
            give_up("no status pulse came for the frame");
        end
    endtask

    task automatic run_row(input int r);
        int           len;
        int           beats;
        int           words;
        int           occ;
        int           idx;
        logic         dropped;
        narrow_beat_t nb;
        wide_word_t   ew;
        len = rows[r].len;
        credits_on = !rows[r].withheld;
        if (credits_on) begin
            wait_drain();
        end
        repeat (4) @(negedge logic_clk);
        // Committed words still waiting in the FIFO
        occ = pushed - chk.words_seen;
        for (int i = 0; i < len; i++) begin
            rng = xorshift32(rng);
            payload[i] = rng[7:0];
        end
        beats = (len + narrow_keep_width - 1) / narrow_keep_width;
        words = (len + wide_keep_width - 1) / wide_keep_width;
        // Uncommitted words are never popped, so the whole frame must fit
        dropped = (occ + words > fifo_depth);
        if (dropped) begin
            exp_ovf++;
        end else if (rows[r].bad) begin
            exp_bad++;
        end else begin
            exp_good++;
            for (int w = 0; w < words; w++) begin
                ew = '0;
                for (int b = 0; b < wide_keep_width; b++) begin
                    idx = w * wide_keep_width + b;
                    if (idx < len) begin
                        ew.data[8*b +: 8] = payload[idx];
                        ew.keep[b] = 1'b1;
                    end
                end
                ew.last = (w == words - 1);
                chk.expect_word(ew);
            end
            pushed += words;
        end
        for (int i = 0; i < beats; i++) begin
            nb = '0;
            for (int j = 0; j < narrow_keep_width; j++) begin
                idx = i * narrow_keep_width + j;
                if (idx < len) begin
                    nb.data[8*j +: 8] = payload[idx];
                    nb.keep[j] = 1'b1;
                end
            end
            nb.last = (i == beats - 1);
            nb.bad  = rows[r].bad && (i == beats / 2);
            @(negedge logic_clk);
            in_beat  = nb;
            in_valid = 1'b1;
        end
        @(negedge logic_clk);
        in_valid = 1'b0;
        in_beat  = '0;
        wait_status(exp_good + exp_bad + exp_ovf);
        if (credits_on) begin
            wait_drain();
        end
        chk.report_test(r, len, exp_good, exp_bad, exp_ovf);
    endtask

    initial begin
        wait_reset_release();
        for (int r = 0; r < num_rows; r++) begin
            run_row(r);
        end
        credits_on = 1'b1;
        wait_drain();
        repeat (4) @(negedge logic_clk);
        chk.final_check(pushed);
        if (chk.error_count == 0) begin
            $display("Regression passed");
        end else begin
            $display("Regression failed");
        end
        $finish;
    end

endmodule

`default_nettype wire
